/* playfield.f */
+incdir+logic
logic/field_pkg.sv
logic/link_pkg.sv
logic/cell_store.sv
logic/line_scan.sv
logic/line_tally.sv
logic/garbage_queue.sv
logic/playfield_top.sv
test/playfield_assertions.sv
test/playfield_tb.sv

/* run.sh */
#!/usr/bin/env bash
# compile and run the playfield engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module playfield_tb \
    -f playfield.f -o playfield_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

output=$(./obj_dir/playfield_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Simulation completed successfully"; then
    exit 0
fi
exit 1

/* test/playfield_tb.sv */
// Playfield engine testbench
`include "playfield_defines.svh"

module playfield_tb
    import field_pkg::*,
           link_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    // ten locks of under 60 cycles each plus the garbage sends leave a wide margin
    localparam int MAX_CYCLES = 3000;

    logic                clk;
    logic                arst_n;
    lock_req_t           lock;
    logic                lock_ready;
    garbage_t            garbage_in;
    credit_t             credit_ret;
    attack_t             attack_out;
    field_t              field;
    logic [`LINES_W-1:0] lines_cleared;

    field_t model;
    col_t   pending_q[$];
    int     model_lines;
    int     model_attacks;
    int     model_attack_lines;
    int     sent;
    int     returned;
    int     attacks_seen;
    int     last_attack;
    int     cycles;
    int     errs;
    int     assert_fails;
    int     tests_passed;
    int     tests_failed;
    int     seed;

    playfield_top uut (
        .clk           (clk),
        .arst_n        (arst_n),
        .lock          (lock),
        .lock_ready    (lock_ready),
        .garbage_in    (garbage_in),
        .credit_ret    (credit_ret),
        .attack_out    (attack_out),
        .field         (field),
        .lines_cleared (lines_cleared)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    // credit and attack outputs only change on the rising edge
    always @(negedge clk) begin
        if (arst_n) begin
            returned <= returned + int'(credit_ret);
            if (attack_out.valid) begin
                attacks_seen <= attacks_seen + 1;
                last_attack  <= int'(attack_out.lines);
            end
        end
    end

    function automatic int attack_for(int n);
        case (n)
            2:       return 1;
            3:       return 2;
            4:       return 4;
            default: return 0;
        endcase
    endfunction

    function automatic cell_t at(int r, int c);
        return '{row: row_t'(r), col: col_t'(c)};
    endfunction

    // loose cell in rows 17 and 18 that keeps column 0 open
    function automatic cell_t rand_cell();
        int r;
        int c;
        r = 17 + int'($unsigned($random(seed)) % 2);
        c = 1 + int'($unsigned($random(seed)) % 7);
        return at(r, c);
    endfunction

    task automatic model_lock(input lock_req_t req);
        field_t stack;
        int     n;
        int     atk;
        int     w;
        col_t   hole;
        n = 0;
        for (int i = 0; i < 4; i++) begin
            model[req.cells[i].row][req.cells[i].col] = 1'b1;
        end
        for (int r = 0; r < `PF_ROWS; r++) begin
            if (&model[r]) begin
                model[r] = '0;
                n++;
            end
        end
        model_lines += n;
        // rows that survive end up stacked on the floor in their old order
        stack = '0;
        w = `PF_ROWS - 1;
        for (int r = `PF_ROWS - 1; r >= 0; r--) begin
            if (model[r] != '0) begin
                stack[w] = model[r];
                w--;
            end
        end
        model = stack;
        atk = attack_for(n);
        while (atk > 0 && pending_q.size() > 0) begin
            void'(pending_q.pop_front());
            atk--;
        end
        if (atk > 0) begin
            model_attacks++;
            model_attack_lines = atk;
        end
        while (pending_q.size() > 0) begin
            hole = pending_q.pop_front();
            for (int r = 0; r < `PF_ROWS - 1; r++) begin
                model[r] = model[r + 1];
            end
            model[`PF_ROWS - 1]       = '1;
            model[`PF_ROWS - 1][hole] = 1'b0;
        end
    endtask

    task automatic check_state();
        if (field !== model) begin
            $display("Mismatch at %0t: field %h, model %h", $time, field, model);
            errs++;
        end
        if (lines_cleared !== `LINES_W'(model_lines)) begin
            $display("Mismatch at %0t: lines_cleared %0d, expected %0d",
                     $time, lines_cleared, model_lines);
            errs++;
        end
        if (attacks_seen != model_attacks || last_attack != model_attack_lines) begin
            $display("Mismatch at %0t: %0d attacks, last %0d, expected %0d, last %0d",
                     $time, attacks_seen, last_attack, model_attacks, model_attack_lines);
            errs++;
        end
        if (sent - returned != pending_q.size()) begin
            $display("Mismatch at %0t: sender credits %0d, expected %0d", $time,
                     `GARBAGE_DEPTH - sent + returned, `GARBAGE_DEPTH - pending_q.size());
            errs++;
        end
    endtask

    task automatic place(input cell_t a, input cell_t b, input cell_t c, input cell_t d);
        lock_req_t req;
        req.valid = 1'b1;
        req.cells = {a, b, c, d};
        @(posedge clk);
        lock <= req;
        @(negedge clk);
        while (!lock_ready)
            @(negedge clk);
        @(posedge clk);
        lock <= '0;
        model_lock(req);
        @(negedge clk);
        while (!lock_ready)
            @(negedge clk);
        check_state();
    endtask

    task automatic send_garbage(input int hole);
        @(posedge clk);
        garbage_in <= '{valid: 1'b1, hole: col_t'(hole)};
        sent = sent + 1;
        pending_q.push_back(col_t'(hole));
        @(posedge clk);
        garbage_in <= '0;
    endtask

    task automatic finish_test(input string name);
        errs += uut.assertions_inst.fail_count - assert_fails;
        assert_fails = uut.assertions_inst.fail_count;
        if (errs == 0) begin
            $display("%s: passed", name);
            tests_passed++;
        end else begin
            $display("%s: failed with %0d errors", name, errs);
            tests_failed++;
        end
        errs = 0;
    endtask

    initial begin
        seed = 22320;
        model = '0;
        arst_n     <= 1'b0;
        lock       <= '0;
        garbage_in <= '0;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        if (!lock_ready || field !== '0 || credit_ret !== '0 || attack_out.valid !== 1'b0) begin
            $display("Mismatch at %0t: outputs not at their reset values", $time);
            errs++;
        end
        finish_test("reset state");

        // bottom row two cells short with loose rows above it
        place(at(19, 0), at(19, 1), at(19, 2), at(19, 3));
        place(at(19, 4), at(19, 5), at(19, 6), at(19, 7));
        repeat (2) begin
            place(rand_cell(), rand_cell(), rand_cell(), rand_cell());
        end
        place(at(18, 8), at(18, 9), at(19, 8), at(19, 9));
        finish_test("single clear and collapse");

        // four garbage rows open in column 0 that a vertical bar fills
        repeat (4) begin
            send_garbage(0);
        end
        place(at(0, 4), at(0, 5), at(1, 4), at(1, 5));
        place(at(16, 0), at(17, 0), at(18, 0), at(19, 0));
        finish_test("four-line clear");

        send_garbage(2);
        send_garbage(5);
        send_garbage(7);
        place(at(0, 4), at(0, 5), at(1, 4), at(1, 5));
        finish_test("garbage rise");

        // the two lowest garbage rows have holes 5 and 7
        send_garbage(1);
        send_garbage(4);
        send_garbage(8);
        place(at(19, 7), at(19, 7), at(18, 5), at(18, 5));
        finish_test("netting");

        while (`GARBAGE_DEPTH - sent + returned > 0) begin
            send_garbage(int'($unsigned($random(seed)) % `PF_COLS));
        end
        place(at(0, 4), at(0, 5), at(1, 4), at(1, 5));
        finish_test("credit bound");

        $display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* test/playfield_assertions.sv */
// Playfield port assertions
`include "playfield_defines.svh"

module playfield_assertions
    import field_pkg::*,
           link_pkg::*;
(
    input logic      clk,
    input logic      arst_n,
    input lock_req_t lock,
    input logic      lock_ready,
    input garbage_t  garbage_in,
    input credit_t   credit_ret,
    input attack_t   attack_out
);
    timeunit 1ns;
    timeprecision 1ps;

    // running totals of garbage lines in and credits out
    logic [15:0] sent_total;
    logic [15:0] ret_total;
    int          fail_count = 0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sent_total <= '0;
            ret_total  <= '0;
        end else begin
            sent_total <= sent_total + 16'(garbage_in.valid);
            ret_total  <= ret_total + 16'(credit_ret);
        end
    end

    reset_quiet: assert property (@(posedge clk)
        !arst_n |-> (!attack_out.valid && credit_ret == '0))
        else begin
            $error("attack or credit output active during reset");
            fail_count++;
        end

    ready_drops: assert property (@(posedge clk) disable iff (!arst_n)
        (lock.valid && lock_ready) |=> !lock_ready)
        else begin
            $error("lock_ready still high after an accepted lock");
            fail_count++;
        end

    attack_single: assert property (@(posedge clk) disable iff (!arst_n)
        attack_out.valid |=> !attack_out.valid)
        else begin
            $error("attack_out valid for two cycles in a row");
            fail_count++;
        end

    // a credit can only come back for a line already received
    credit_bound: assert property (@(posedge clk) disable iff (!arst_n)
        (ret_total + 16'(credit_ret)) <= sent_total)
        else begin
            $error("more credits returned than garbage lines sent");
            fail_count++;
        end

endmodule

bind playfield_top playfield_assertions assertions_inst (
    .clk        (clk),
    .arst_n     (arst_n),
    .lock       (lock),
    .lock_ready (lock_ready),
    .garbage_in (garbage_in),
    .credit_ret (credit_ret),
    .attack_out (attack_out)
);

/* logic/playfield_top.sv */
// Playfield engine top
`include "playfield_defines.svh"

module playfield_top
    import field_pkg::*,
           link_pkg::*;
(
    input  logic                clk,
    input  logic                arst_n,

    input  lock_req_t           lock,
    output logic                lock_ready,

    input  garbage_t            garbage_in,
    output credit_t             credit_ret,
    output attack_t             attack_out,

    output field_t              field,
    output logic [`LINES_W-1:0] lines_cleared
);

    logic                lock_fire;
    logic [`PF_ROWS-1:0] row_full;
    logic [`PF_ROWS-1:0] row_floating;
    logic                settled;
    logic                tally_valid;
    logic [`LINES_W-1:0] tally_lines;
    garbage_t            rise;

    cell_store cell_store_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .lock         (lock),
        .lock_ready   (lock_ready),
        .rise         (rise),
        .row_full     (row_full),
        .row_floating (row_floating),
        .lock_fire    (lock_fire),
        .field        (field)
    );

    line_scan line_scan_inst (
        .field        (field),
        .row_full     (row_full),
        .row_floating (row_floating),
        .settled      (settled)
    );

    line_tally line_tally_inst (
        .clk           (clk),
        .arst_n        (arst_n),
        .lock_fire     (lock_fire),
        .row_full      (row_full),
        .tally_valid   (tally_valid),
        .tally_lines   (tally_lines),
        .lines_cleared (lines_cleared)
    );

    garbage_queue garbage_queue_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .garbage_in  (garbage_in),
        .lock_fire   (lock_fire),
        .settled     (settled),
        .tally_valid (tally_valid),
        .tally_lines (tally_lines),
        .lock_ready  (lock_ready),
        .rise        (rise),
        .credit_ret  (credit_ret),
        .attack_out  (attack_out)
    );

endmodule

/* logic/garbage_queue.sv */
// Pending garbage queue
`include "playfield_defines.svh"

module garbage_queue
    import field_pkg::*,
           link_pkg::*;
(
    input  logic                clk,
    input  logic                arst_n,

    input  garbage_t            garbage_in,
    input  logic                lock_fire,
    input  logic                settled,
    input  logic                tally_valid,
    input  logic [`LINES_W-1:0] tally_lines,

    output logic                lock_ready,
    output garbage_t            rise,
    output credit_t             credit_ret,
    output attack_t             attack_out
);

    localparam int PTR_W = $clog2(`GARBAGE_DEPTH);

    col_t                holes [`GARBAGE_DEPTH];
    logic [PTR_W-1:0]    head;
    logic [PTR_W-1:0]    tail;
    credit_t             count;
    logic                busy;
    logic                netted;
    logic                drain;
    logic                done;
    logic [`LINES_W-1:0] pending_ext;
    logic [`LINES_W-1:0] drop_w;
    logic [`LINES_W-1:0] remaining;
    credit_t             drop;

    // netting cancels the smaller of attack and pending
    assign pending_ext = `LINES_W'(count);
    assign drop_w      = (tally_lines < pending_ext) ? tally_lines : pending_ext;
    assign drop        = tally_valid ? credit_t'(drop_w) : '0;
    assign remaining   = tally_lines - drop_w;

    assign attack_out.valid = tally_valid && (remaining != '0);
    assign attack_out.lines = remaining;

    // one line per cycle once netted and the field has come to rest
    assign drain      = busy && netted && settled && (count != '0);
    assign rise.valid = drain;
    assign rise.hole  = holes[head];

    // every popped entry frees one credit
    assign credit_ret = drain ? credit_t'(1) : drop;

    assign done       = busy && netted && settled && (count == '0);
    assign lock_ready = !busy;

    always_ff @(posedge clk) begin
        if (garbage_in.valid) begin
            holes[tail] <= garbage_in.hole;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (garbage_in.valid) begin
                tail <= tail + 1'b1;
            end
            head  <= head + PTR_W'(credit_ret);
            count <= count + credit_t'(garbage_in.valid) - credit_ret;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy   <= 1'b0;
            netted <= 1'b0;
        end else if (lock_fire) begin
            busy   <= 1'b1;
            netted <= 1'b0;
        end else if (done) begin
            busy   <= 1'b0;
            netted <= 1'b0;
        end else if (tally_valid) begin
            netted <= 1'b1;
        end
    end

endmodule

/* logic/line_tally.sv */
// Cleared line and attack tally
`include "playfield_defines.svh"

module line_tally
    import field_pkg::*,
           link_pkg::*;
(
    input  logic                clk,
    input  logic                arst_n,

    input  logic                lock_fire,
    input  logic [`PF_ROWS-1:0] row_full,

    output logic                tally_valid,
    output logic [`LINES_W-1:0] tally_lines,
    output logic [`LINES_W-1:0] lines_cleared
);

    logic                fire_d;
    row_t                full_cnt;
    logic [`LINES_W-1:0] attack;
    attack_t             tally_q;

    // a row count fits a row index
    always_comb begin
        full_cnt = '0;
        for (int i = 0; i < `PF_ROWS; i++) begin
            full_cnt = full_cnt + row_t'(row_full[i]);
        end
    end

    always_comb begin
        case (full_cnt)
            row_t'(2): attack = `LINES_W'(1);
            row_t'(3): attack = `LINES_W'(2);
            row_t'(4): attack = `LINES_W'(4);
            default:   attack = '0;
        endcase
    end

    // full rows are visible the cycle after the lock lands
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fire_d        <= 1'b0;
            tally_q       <= '0;
            lines_cleared <= '0;
        end else begin
            fire_d        <= lock_fire;
            tally_q.valid <= fire_d;
            if (fire_d) begin
                tally_q.lines <= attack;
                lines_cleared <= lines_cleared + `LINES_W'(full_cnt);
            end
        end
    end

    assign tally_valid = tally_q.valid;
    assign tally_lines = tally_q.lines;

endmodule

/* logic/line_scan.sv */
// Row status scan
`include "playfield_defines.svh"

module line_scan
    import field_pkg::*;
(
    input  field_t              field,

    output logic [`PF_ROWS-1:0] row_full,
    output logic [`PF_ROWS-1:0] row_floating,
    output logic                settled
);

    logic [`PF_ROWS-1:0] row_empty;

    always_comb begin
        for (int i = 0; i < `PF_ROWS; i++) begin
            row_full[i]  = &field[i];
            row_empty[i] = ~|field[i];
        end
    end

    always_comb begin
        for (int i = 0; i < `PF_ROWS - 1; i++) begin
            row_floating[i] = !row_empty[i] && row_empty[i + 1];
        end
        // bottom row always rests on the floor
        row_floating[`PF_ROWS - 1] = 1'b0;
    end

    assign settled = !(|row_full) && !(|row_floating);

endmodule

/* logic/cell_store.sv */
// Stored playfield
`include "playfield_defines.svh"

module cell_store
    import field_pkg::*,
           link_pkg::*;
(
    input  logic                clk,
    input  logic                arst_n,

    input  lock_req_t           lock,
    input  logic                lock_ready,
    input  garbage_t            rise,
    input  logic [`PF_ROWS-1:0] row_full,
    input  logic [`PF_ROWS-1:0] row_floating,

    output logic                lock_fire,
    output field_t              field
);

    logic      any_full;
    logic      any_floating;
    row_bits_t garbage_row;

    assign lock_fire    = lock.valid && lock_ready;
    assign any_full     = |row_full;
    assign any_floating = |row_floating;

    // every column filled except the hole
    assign garbage_row  = ~(row_bits_t'(1) << rise.hole);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            field <= '0;
        end else if (lock_fire) begin
            for (int i = 0; i < 4; i++) begin
                field[lock.cells[i].row][lock.cells[i].col] <= 1'b1;
            end
        end else if (any_full) begin
            for (int i = 0; i < `PF_ROWS; i++) begin
                if (row_full[i]) begin
                    field[i] <= '0;
                end
            end
        end else if (rise.valid) begin
            // whole stack moves up, top row is pushed out
            for (int i = 0; i < `PF_ROWS - 1; i++) begin
                field[i] <= field[i + 1];
            end
            field[`PF_ROWS - 1] <= garbage_row;
        end else if (any_floating) begin
            // a floating row sits on an empty one, so no two moves overlap
            for (int i = 0; i < `PF_ROWS - 1; i++) begin
                if (row_floating[i]) begin
                    field[i + 1] <= field[i];
                    field[i]     <= '0;
                end
            end
        end
    end

endmodule

/* logic/link_pkg.sv */
// Engine link types
`include "playfield_defines.svh"

package link_pkg;

    import field_pkg::*;

    // four cells of a settled piece
    typedef struct packed {
        logic        valid;
        cell_t [3:0] cells;
    } lock_req_t;

    // one incoming garbage line, hole chosen by the sender
    typedef struct packed {
        logic valid;
        col_t hole;
    } garbage_t;

    typedef struct packed {
        logic                valid;
        logic [`LINES_W-1:0] lines;
    } attack_t;

    // credits handed back to the garbage sender
    typedef logic [$clog2(`GARBAGE_DEPTH + 1)-1:0] credit_t;

endpackage

/* logic/field_pkg.sv */
// Field types
`include "playfield_defines.svh"

package field_pkg;

    // row 0 is the top of the field, row PF_ROWS-1 the bottom
    typedef logic [4:0] row_t;
    typedef logic [3:0] col_t;

    typedef struct packed {
        row_t row;
        col_t col;
    } cell_t;

    // one bit per column, set when occupied
    typedef logic [`PF_COLS-1:0] row_bits_t;

    typedef row_bits_t [`PF_ROWS-1:0] field_t;

endpackage

/* logic/playfield_defines.svh */
// Playfield engine sizes
`ifndef PLAYFIELD_DEFINES_SVH
`define PLAYFIELD_DEFINES_SVH

// stored field dimensions
`define PF_ROWS 20
`define PF_COLS 10

// pending garbage entries, also the sender's starting credits
`define GARBAGE_DEPTH 8

// cleared-lines total and attack value
`define LINES_W 10

`endif
